/* sources.f */
+incdir+src
src/mem_map_pkg.sv
src/sdram_req_pkg.sv
src/slot_arbiter.sv
src/req_fifo.sv
src/bank_sequencer.sv
src/cps_sdram_top.sv
sim/sdram_model.sv
sim/tb_cps_sdram.sv

/* Makefile */
# Verilator build for the SDRAM slot controller testbench

TOOL   = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = tb_cps_sdram
FLIST  = sources.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# Pass only when the log holds the pass line
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/tb_cps_sdram.sv */
// ====================
// Testbench for the SDRAM slot controller
// Slot traffic, reference memory and property checks
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module tb_cps_sdram;

localparam int N_PAIRS     = 12;   // Write then read back on slot 0
localparam int N_GFX       = 12;
localparam int N_HITS      = 4;
localparam int N_BOTH      = 20;   // Per slot with both slots busy
localparam int TOTAL_TX    = 2 * N_PAIRS + N_GFX + 2 * N_HITS + 2 * N_BOTH;
localparam int RESET_CYC   = 16;
localparam int WATCHDOG_NS = TOTAL_TX * 40 * 10 + RESET_CYC * 10;

logic               clk = 1'b0;
logic               reset;
logic               wram_cs, wram_wen;
logic [16:0]        wram_addr;
logic [15:0]        wram_din;
logic [1:0]         wram_mask;
logic               gfx_cs;
logic [19:0]        gfx_addr;
wire                wram_ok, gfx_ok;
wire  [15:0]        wram_dout;
wire  [31:0]        gfx_dout;
wire  [`SDRAMW-1:0] sdram_addr;
wire                sdram_rd, sdram_wr, sdram_ack, data_dst, data_rdy;
wire  [15:0]        sdram_din, data_read;
wire  [1:0]         sdram_mask;

logic               cs_seen, wram_chk, gfx_chk, hit_probe, no_access;
logic [15:0]        wram_exp;
logic [31:0]        gfx_exp;
logic [15:0]        ref_mem [int];   // Words written so far
int                 errors = 0;
int                 tx_done = 0;

always #5 clk = ~clk;

cps_sdram_top dut0 (.*);
sdram_model   u_model (.*);

function automatic logic [15:0] ref_read(input int addr);
    if (ref_mem.exists(addr)) return ref_mem[addr];
    return addr[15:0] ^ 16'hA5C3;
endfunction

function automatic logic [16:0] pick_wram();
    if ($urandom_range(1, 0) == 0) return 17'($urandom_range(7, 0));   // Small pool
    return 17'($urandom);
endfunction

a_quiet: assert property (@(posedge clk)
        !reset && !cs_seen |-> !(wram_ok || gfx_ok || sdram_rd || sdram_wr))
    else begin
        errors++;
        $display("An ok or bank strobe went high at %0t before any request", $time);
    end

a_wram_data: assert property (@(posedge clk) disable iff (reset)
        wram_chk && wram_ok |-> wram_dout == wram_exp)
    else begin
        errors++;
        $display("ERR %0t wram_dout expected %h got %h", $time,
                 $sampled(wram_exp), $sampled(wram_dout));
    end

a_gfx_data: assert property (@(posedge clk) disable iff (reset)
        gfx_chk && gfx_ok |-> gfx_dout == gfx_exp)
    else begin
        errors++;
        $display("ERR %0t gfx_dout expected %h got %h", $time,
                 $sampled(gfx_exp), $sampled(gfx_dout));
    end

a_hit_ok: assert property (@(posedge clk) disable iff (reset) hit_probe |-> wram_ok)
    else begin
        errors++;
        $display("ERR %0t wram_ok expected 1 got %b", $time, $sampled(wram_ok));
    end

a_hit_quiet: assert property (@(posedge clk) disable iff (reset) no_access |-> !sdram_rd)
    else begin
        errors++;
        $display("ERR %0t sdram_rd expected 0 got %b", $time, $sampled(sdram_rd));
    end

a_wr_region: assert property (@(posedge clk) disable iff (reset)
        sdram_wr |-> sdram_addr >= `WRAM_OFFSET)
    else begin
        errors++;
        $display("A write reached the bank outside work RAM at %0t", $time);
    end

task automatic wram_access(input logic wen, input logic [16:0] addr,
                           input logic [15:0] din, input logic [1:0] mask);
    int          sa;
    logic [15:0] old;
    sa  = int'(`WRAM_OFFSET + {6'd0, addr});
    old = ref_read(sa);
    @(posedge clk);
    cs_seen   <= 1'b1;
    wram_cs   <= 1'b1;
    wram_wen  <= wen;
    wram_addr <= addr;
    wram_din  <= din;
    wram_mask <= mask;
    wram_chk  <= !wen;
    wram_exp  <= old;
    do @(negedge clk); while (!wram_ok);
    if (wen) begin
        ref_mem[sa] = {mask[1] ? old[15:8] : din[15:8],
                       mask[0] ? old[7:0]  : din[7:0]};   // Active low byte mask
    end
    @(posedge clk);
    wram_cs  <= 1'b0;
    wram_chk <= 1'b0;
    tx_done++;
endtask

task automatic gfx_read(input logic [19:0] addr);
    int sa;
    sa = int'(`ROM_OFFSET + {2'd0, addr, 1'b0});
    @(posedge clk);
    cs_seen  <= 1'b1;
    gfx_cs   <= 1'b1;
    gfx_addr <= addr;
    gfx_chk  <= 1'b1;
    gfx_exp  <= {ref_read(sa + 1), ref_read(sa)};   // Upper word in the high half
    do @(negedge clk); while (!gfx_ok);
    @(posedge clk);
    gfx_cs  <= 1'b0;
    gfx_chk <= 1'b0;
    tx_done++;
endtask

// Re-read of an address just served and answered from the latch
task automatic hit_recheck(input logic [16:0] addr);
    @(posedge clk);
    wram_cs   <= 1'b1;
    wram_wen  <= 1'b0;
    wram_addr <= addr;
    wram_chk  <= 1'b1;
    wram_exp  <= ref_read(int'(`WRAM_OFFSET + {6'd0, addr}));
    no_access <= 1'b1;
    @(posedge clk);
    hit_probe <= 1'b1;   // ok due in this cycle
    @(posedge clk);
    hit_probe <= 1'b0;
    wram_cs   <= 1'b0;
    wram_chk  <= 1'b0;
    repeat (4) @(posedge clk);   // A miss would show on the bank by now
    no_access <= 1'b0;
    tx_done++;
endtask

initial begin
    logic [16:0] a;
    logic [19:0] g;
    void'($urandom(37440));
    reset     <= 1'b1;
    wram_cs   <= 1'b0;
    wram_wen  <= 1'b0;
    wram_addr <= 17'h0;
    wram_din  <= 16'h0;
    wram_mask <= 2'b11;
    gfx_cs    <= 1'b0;
    gfx_addr  <= 20'h0;
    cs_seen   <= 1'b0;
    wram_chk  <= 1'b0;
    gfx_chk   <= 1'b0;
    hit_probe <= 1'b0;
    no_access <= 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    reset <= 1'b0;
    repeat (8) @(posedge clk);
    for (int i = 0; i < N_PAIRS; i++) begin
        a = pick_wram();
        wram_access(1'b1, a, 16'($urandom), 2'($urandom));
        wram_access(1'b0, a, 16'h0, 2'b11);
    end
    for (int i = 0; i < N_GFX; i++) begin
        if (i % 2 == 0) g = 20'($urandom);   // Odd passes repeat the address
        gfx_read(g);
    end
    for (int i = 0; i < N_HITS; i++) begin
        a = pick_wram();
        wram_access(1'b0, a, 16'h0, 2'b11);
        hit_recheck(a);
    end
    // Both slots at once with the first misses in the same cycle
    fork
        for (int i = 0; i < N_BOTH; i++) begin
            wram_access(1'($urandom), pick_wram(), 16'($urandom), 2'($urandom));
        end
        for (int i = 0; i < N_BOTH; i++) begin
            gfx_read(20'($urandom));
        end
    join
    repeat (4) @(posedge clk);
    $display("Run complete: %0d of %0d transactions, %0d errors", tx_done, TOTAL_TX, errors);
    if (errors == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d transactions done", WATCHDOG_NS, tx_done);
    $display("** FAIL **");
    $finish;
end

endmodule

`default_nettype wire

/* sim/sdram_model.sv */
// ====================
// SDRAM bank model
// Random ack delay, two-beat reads and masked writes
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_model (
    input  wire                 clk,
    input  wire                 reset,
    input  wire  [`SDRAMW-1:0]  sdram_addr,
    input  wire                 sdram_rd,
    input  wire                 sdram_wr,
    input  wire  [15:0]         sdram_din,
    input  wire  [1:0]          sdram_mask,
    output logic                sdram_ack,
    output logic                data_dst,
    output logic                data_rdy,
    output logic [15:0]         data_read
);

localparam logic [1:0] M_IDLE  = 2'd0,
                       M_WAIT  = 2'd1,   // Counting down the ack delay
                       M_BEAT0 = 2'd2,
                       M_BEAT1 = 2'd3;   // Last read beat with rdy

logic [15:0]        mem [int];   // Only words that were written
logic [1:0]         state;
logic [2:0]         delay;
logic [`SDRAMW-1:0] addr;
logic               is_wr;
logic [15:0]        wdata;
logic [1:0]         wmask;

function automatic logic [15:0] read_word(input logic [`SDRAMW-1:0] a);
    if (mem.exists(int'(a))) return mem[int'(a)];
    return a[15:0] ^ 16'hA5C3;   // Power-up contents
endfunction

always @(posedge clk) begin
    logic [15:0] old;
    sdram_ack <= 1'b0;
    data_dst  <= 1'b0;
    data_rdy  <= 1'b0;
    if (reset) begin
        state     <= M_IDLE;
        data_read <= 16'h0;
    end else begin
        case (state)
            M_IDLE: if (sdram_rd || sdram_wr) begin
                addr  <= sdram_addr;
                is_wr <= sdram_wr;
                wdata <= sdram_din;
                wmask <= sdram_mask;
                delay <= 3'($urandom_range(7, 0));
                state <= M_WAIT;
            end
            M_WAIT: begin
                if (delay == 3'd0) begin
                    sdram_ack <= 1'b1;
                    state     <= M_BEAT0;
                end else begin
                    delay <= delay - 1'b1;
                end
            end
            M_BEAT0: begin
                if (is_wr) begin
                    old = read_word(addr);
                    // Mask bit set keeps the old byte
                    mem[int'(addr)] = {wmask[1] ? old[15:8] : wdata[15:8],
                                       wmask[0] ? old[7:0]  : wdata[7:0]};
                    data_rdy <= 1'b1;
                    state    <= M_IDLE;
                end else begin
                    data_dst  <= 1'b1;
                    data_read <= read_word(addr);
                    state     <= M_BEAT1;
                end
            end
            default: begin
                data_dst  <= 1'b1;
                data_rdy  <= 1'b1;
                data_read <= read_word(addr + 1'b1);   // Burst of two
                state     <= M_IDLE;
            end
        endcase
    end
end

endmodule

`default_nettype wire

/* src/cps_sdram_top.sv */
// ====================
// SDRAM slot controller top
// Arbiter, request FIFO and bank sequencer on one bank
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module cps_sdram_top (
    input  wire                 clk,
    input  wire                 reset,
    // Slot 0, main CPU work RAM
    input  wire                 wram_cs,
    input  wire                 wram_wen,
    input  wire  [16:0]         wram_addr,
    input  wire  [15:0]         wram_din,
    input  wire  [1:0]          wram_mask,
    output wire                 wram_ok,
    output wire  [15:0]         wram_dout,
    // Slot 1, graphics ROM
    input  wire                 gfx_cs,
    input  wire  [19:0]         gfx_addr,
    output wire                 gfx_ok,
    output wire  [31:0]         gfx_dout,
    // SDRAM bank
    output wire  [`SDRAMW-1:0]  sdram_addr,
    output wire                 sdram_rd,
    output wire                 sdram_wr,
    output wire  [15:0]         sdram_din,
    output wire  [1:0]          sdram_mask,
    input  wire                 sdram_ack,
    input  wire                 data_dst,
    input  wire                 data_rdy,
    input  wire  [15:0]         data_read
);

wire sdram_req_pkg::req_word_u req_word, fifo_word;
wire mem_map_pkg::slot_id_e    resp_slot;
wire [31:0]                    resp_data;
wire                           push, pop, full, empty, resp_valid;

slot_arbiter u_arbiter (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .wram_cs    ( wram_cs    ),
    .wram_wen   ( wram_wen   ),
    .wram_addr  ( wram_addr  ),
    .wram_din   ( wram_din   ),
    .wram_mask  ( wram_mask  ),
    .wram_ok    ( wram_ok    ),
    .wram_dout  ( wram_dout  ),
    .gfx_cs     ( gfx_cs     ),
    .gfx_addr   ( gfx_addr   ),
    .gfx_ok     ( gfx_ok     ),
    .gfx_dout   ( gfx_dout   ),
    .full       ( full       ),
    .push       ( push       ),
    .req_word   ( req_word   ),
    .resp_valid ( resp_valid ),
    .resp_slot  ( resp_slot  ),
    .resp_data  ( resp_data  )
);

req_fifo u_fifo (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .push       ( push       ),
    .pop        ( pop        ),
    .wr_word    ( req_word   ),
    .rd_word    ( fifo_word  ),
    .full       ( full       ),
    .empty      ( empty      )
);

bank_sequencer u_sequencer (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .rd_word    ( fifo_word  ),
    .empty      ( empty      ),
    .pop        ( pop        ),
    .sdram_addr ( sdram_addr ),
    .sdram_rd   ( sdram_rd   ),
    .sdram_wr   ( sdram_wr   ),
    .sdram_din  ( sdram_din  ),
    .sdram_mask ( sdram_mask ),
    .sdram_ack  ( sdram_ack  ),
    .data_dst   ( data_dst   ),
    .data_rdy   ( data_rdy   ),
    .data_read  ( data_read  ),
    .resp_valid ( resp_valid ),
    .resp_slot  ( resp_slot  ),
    .resp_data  ( resp_data  )
);

endmodule

`default_nettype wire

/* src/bank_sequencer.sv */
// ====================
// Bank sequencer
// Runs one SDRAM transaction at a time and returns the response
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module bank_sequencer (
    input  wire                             clk,
    input  wire                             reset,
    // Request FIFO
    input  wire  sdram_req_pkg::req_word_u  rd_word,
    input  wire                             empty,
    output logic                            pop,
    // SDRAM bank
    output logic [`SDRAMW-1:0]              sdram_addr,
    output logic                            sdram_rd,
    output logic                            sdram_wr,
    output logic [15:0]                     sdram_din,
    output logic [1:0]                      sdram_mask,
    input  wire                             sdram_ack,
    input  wire                             data_dst,
    input  wire                             data_rdy,
    input  wire  [15:0]                     data_read,
    // Response to the arbiter
    output logic                            resp_valid,
    output mem_map_pkg::slot_id_e           resp_slot,
    output logic [31:0]                     resp_data
);

localparam logic [1:0] S_IDLE    = 2'd0,
                       S_REQUEST = 2'd1,   // Strobe up, waiting for ack
                       S_DATA    = 2'd2,   // Beats and rdy
                       S_RESPOND = 2'd3;

logic [1:0] state;
logic       two_beats;
logic       beat;      // Next beat goes to the upper half

assign pop        = state == S_IDLE && !empty;
assign resp_valid = state == S_RESPOND;

always_ff @(posedge clk) begin
    if (reset) begin
        state    <= S_IDLE;
        sdram_rd <= 1'b0;
        sdram_wr <= 1'b0;
    end else begin
        case (state)
            S_IDLE: if (pop) begin
                state    <= S_REQUEST;
                sdram_wr <= rd_word.wr.write;
                sdram_rd <= !rd_word.wr.write;
            end
            S_REQUEST: if (sdram_ack) begin
                state    <= S_DATA;
                sdram_rd <= 1'b0;
                sdram_wr <= 1'b0;
            end
            S_DATA: if (data_rdy) state <= S_RESPOND;
            default: state <= S_IDLE;   // Response pulse lasts one cycle
        endcase
    end
end

always_ff @(posedge clk) begin
    if (pop) begin
        beat <= 1'b0;
        if (rd_word.wr.write) begin
            sdram_addr <= rd_word.wr.addr;
            sdram_din  <= rd_word.wr.data;
            sdram_mask <= rd_word.wr.mask;
            resp_slot  <= mem_map_pkg::SLOT_WRAM;
            two_beats  <= 1'b0;
        end else begin
            sdram_addr <= rd_word.rd.addr;
            sdram_mask <= 2'b11;
            resp_slot  <= rd_word.rd.slot;
            two_beats  <= rd_word.rd.beats;
        end
    end
    if (state == S_DATA && data_dst) begin
        if (!beat) resp_data[15:0] <= data_read;
        else if (two_beats) resp_data[31:16] <= data_read;   // Upper address word
        beat <= 1'b1;
    end
end

endmodule

`default_nettype wire

/* src/req_fifo.sv */
// ====================
// Request FIFO
// Circular buffer of request words
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module req_fifo (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             push,
    input  wire                             pop,
    input  wire  sdram_req_pkg::req_word_u  wr_word,
    output sdram_req_pkg::req_word_u        rd_word,
    output logic                            full,
    output logic                            empty
);

localparam int DEPTH = `REQ_FIFO_DEPTH;
localparam int AW    = $clog2(DEPTH);
localparam logic [AW:0] FULL_CNT = DEPTH[AW:0];

sdram_req_pkg::req_word_u mem [DEPTH];
logic [AW-1:0] wr_ptr, rd_ptr;
logic [AW:0]   count;
logic          do_push, do_pop;

function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

assign full    = count == FULL_CNT;
assign empty   = count == '0;
assign do_pop  = pop && !empty;
assign do_push = push && (!full || do_pop);   // Full but draining still accepts
assign rd_word = mem[rd_ptr];                 // Head is valid while not empty

always_ff @(posedge clk) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push) wr_ptr <= ptr_next(wr_ptr);
        if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wr_word;
end

endmodule

`default_nettype wire

/* src/slot_arbiter.sv */
// ====================
// Slot arbiter
// Latches slot data, answers hits and pushes misses as request words
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "sdram_defines.svh"

module slot_arbiter (
    input  wire                             clk,
    input  wire                             reset,
    // Slot 0, work RAM
    input  wire                             wram_cs,
    input  wire                             wram_wen,
    input  wire  [16:0]                     wram_addr,
    input  wire  [15:0]                     wram_din,
    input  wire  [1:0]                      wram_mask,
    output logic                            wram_ok,
    output logic [15:0]                     wram_dout,
    // Slot 1, graphics ROM
    input  wire                             gfx_cs,
    input  wire  [19:0]                     gfx_addr,
    output logic                            gfx_ok,
    output logic [31:0]                     gfx_dout,
    // Request FIFO
    input  wire                             full,
    output logic                            push,
    output sdram_req_pkg::req_word_u        req_word,
    // Response from the sequencer
    input  wire                             resp_valid,
    input  wire  mem_map_pkg::slot_id_e     resp_slot,
    input  wire  [31:0]                     resp_data
);

logic [16:0] wram_laddr, wram_raddr, wram_saddr;
logic [15:0] wram_ldata, wram_rdin, wram_merge;
logic [1:0]  wram_rmask;
logic        wram_rwen, wram_swen;
logic        wram_valid, wram_pend, wram_ok_q;
logic [19:0] gfx_laddr, gfx_raddr;
logic [31:0] gfx_ldata;
logic        gfx_valid, gfx_pend, gfx_ok_q;
logic        wram_hit, wram_keep, wram_want, wram_push, wram_resp;
logic        gfx_hit, gfx_want, gfx_push, gfx_resp;
mem_map_pkg::region_t wram_sdaddr, gfx_sdaddr;

assign wram_sdaddr = `WRAM_OFFSET + {6'd0, wram_addr};
assign gfx_sdaddr  = `ROM_OFFSET + {2'd0, gfx_addr, 1'b0};   // Two words per entry

// Writes never hit, they always reach the SDRAM
assign wram_hit  = wram_cs && !wram_wen && wram_valid && wram_addr == wram_laddr;
assign wram_keep = wram_ok_q && wram_cs && wram_addr == wram_saddr && wram_wen == wram_swen;
assign wram_want = wram_cs && !wram_hit && !wram_keep && !wram_pend;
assign gfx_hit   = gfx_cs && gfx_valid && gfx_addr == gfx_laddr;
assign gfx_want  = gfx_cs && !gfx_hit && !gfx_pend;

assign push      = !full && (wram_want || gfx_want);
assign wram_push = push && wram_want;                 // Slot 0 wins a tie
assign gfx_push  = push && !wram_want && gfx_want;
assign wram_resp = resp_valid && resp_slot == mem_map_pkg::SLOT_WRAM;
assign gfx_resp  = resp_valid && resp_slot == mem_map_pkg::SLOT_GFX;

assign wram_merge = { wram_rmask[1] ? wram_ldata[15:8] : wram_rdin[15:8],
                      wram_rmask[0] ? wram_ldata[7:0]  : wram_rdin[7:0] };

assign wram_ok   = wram_keep;              // Drops as soon as the client moves on
assign wram_dout = wram_ldata;
assign gfx_ok    = gfx_ok_q && gfx_hit;
assign gfx_dout  = gfx_ldata;

always_comb begin
    req_word = '0;
    if (wram_want) begin
        if (wram_wen) begin
            req_word.wr.write = 1'b1;
            req_word.wr.addr  = wram_sdaddr;
            req_word.wr.data  = wram_din;
            req_word.wr.mask  = wram_mask;
        end else begin
            req_word.rd.addr  = wram_sdaddr;
            req_word.rd.slot  = mem_map_pkg::SLOT_WRAM;
        end
    end else begin
        req_word.rd.addr  = gfx_sdaddr;
        req_word.rd.slot  = mem_map_pkg::SLOT_GFX;
        req_word.rd.beats = 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        wram_valid <= 1'b0;
        wram_pend  <= 1'b0;
        wram_ok_q  <= 1'b0;
        gfx_valid  <= 1'b0;
        gfx_pend   <= 1'b0;
        gfx_ok_q   <= 1'b0;
    end else begin
        wram_ok_q <= wram_resp || wram_hit || wram_keep;
        gfx_ok_q  <= gfx_resp || gfx_hit;
        if (wram_push) wram_pend <= 1'b1;
        else if (wram_resp) wram_pend <= 1'b0;
        if (gfx_push) gfx_pend <= 1'b1;
        else if (gfx_resp) gfx_pend <= 1'b0;
        if (wram_resp) begin
            if (!wram_rwen) wram_valid <= 1'b1;
            else if (wram_laddr != wram_raddr) wram_valid <= 0;   // Latch no longer trusted
        end
        if (gfx_resp) gfx_valid <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (wram_push) begin
        wram_raddr <= wram_addr;
        wram_rdin  <= wram_din;
        wram_rmask <= wram_mask;
        wram_rwen  <= wram_wen;
    end
    if (gfx_push) gfx_raddr <= gfx_addr;
    // Access that currently holds ok high
    wram_saddr <= wram_resp ? wram_raddr : wram_addr;
    wram_swen  <= wram_resp ? wram_rwen  : wram_wen;
    if (wram_resp) begin
        if (!wram_rwen) begin
            wram_laddr <= wram_raddr;
            wram_ldata <= resp_data[15:0];
        end else if (wram_valid && wram_laddr == wram_raddr) begin
            wram_ldata <= wram_merge;
        end
    end
    if (gfx_resp) begin
        gfx_laddr <= gfx_raddr;
        gfx_ldata <= resp_data;
    end
end

endmodule

`default_nettype wire

/* src/sdram_req_pkg.sv */
// ====================
// Request word package
// One 42-bit word seen as a read or as a write
// ====================
`default_nettype none

`include "sdram_defines.svh"

package sdram_req_pkg;

    localparam int REQ_W    = 42;
    localparam int RD_PAD_W = REQ_W - `SDRAMW - 3;   // Write flag, slot and beat count

    // Read view
    typedef struct packed {
        logic                  write;   // Low for reads
        mem_map_pkg::region_t  addr;
        logic [RD_PAD_W-1:0]   pad;
        mem_map_pkg::slot_id_e slot;
        logic                  beats;   // Set for two beats
    } req_rd_t;

    // Write view, slot 0 only
    typedef struct packed {
        logic                  write;   // High for writes
        mem_map_pkg::region_t  addr;
        logic [15:0]           data;
        logic [1:0]            mask;    // Active low byte enables
    } req_wr_t;

    // Flag and address sit at the same bits in both views
    typedef union packed {
        req_rd_t rd;
        req_wr_t wr;
    } req_word_u;

endpackage

`default_nettype wire

/* src/mem_map_pkg.sv */
// ====================
// Memory map package
// Slot identifiers and the SDRAM word-address type
// ====================
`default_nettype none

`include "sdram_defines.svh"

package mem_map_pkg;

    // Client that owns a request or a response
    typedef enum logic {
        SLOT_WRAM = 1'b0,   // Main CPU work RAM, read and write
        SLOT_GFX  = 1'b1    // Graphics ROM, 32-bit reads
    } slot_id_e;

    // Word address into the SDRAM bank
    typedef logic [`SDRAMW-1:0] region_t;

endpackage

`default_nettype wire

/* src/sdram_defines.svh */
// ====================
// SDRAM controller defines
// Address width, region bases and request FIFO depth
// ====================
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// SDRAM word-address width
`define SDRAMW          23

// Region bases inside the single bank
`define WRAM_OFFSET     23'h30_0000     // Main CPU work RAM
`define ROM_OFFSET      23'h00_0000     // Graphics ROM

// Pending request words between arbiter and sequencer
`define REQ_FIFO_DEPTH  4

`endif
